//--- all.f
rtl/icache_pkg.sv
rtl/icache_way_ram.sv
rtl/icache_lookup.sv
rtl/icache_hit_select.sv
rtl/icache_refill.sv
rtl/icache_flush.sv
rtl/icache_top.sv
dv/tb_clock_gen.sv
dv/tb_icache_mem.sv
dv/tb_icache.sv

//--- run.sh
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_icache -f all.f -o sim_icache
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1

//--- dv/tb_icache.sv
// Testbench top with the stimulus table, response checks, counters and timeout
`timescale 1ns/1ns
`default_nettype none

module tb_icache import icache_pkg::*; ();

  typedef struct packed {
    logic [63:0] addr;
    logic        flush;
    logic        fault;
    logic        miss;
    logic        chain;
  } row_t;

  localparam int unsigned NumRows       = 27;
  localparam int unsigned TimeoutCycles = NumRows * 100 + 200;
  localparam logic [31:0] InstrKey      = 32'h5a5a0000;

  // Columns are address, flush, expected fault, expected miss, next row back to back
  localparam row_t Rows [NumRows] = '{
    '{64'h0000_0000_0002_0140, 1'b0, 1'b0, 1'b1, 1'b0},  // Set 5 fills way 0
    '{64'h0000_0000_0002_1140, 1'b0, 1'b0, 1'b1, 1'b0},
    '{64'h0000_0000_0002_2140, 1'b0, 1'b0, 1'b1, 1'b0},
    '{64'h0000_0000_0002_3140, 1'b0, 1'b0, 1'b1, 1'b0},
    '{64'h0000_0000_0002_4140, 1'b0, 1'b0, 1'b1, 1'b0},  // Pointer at 0 evicts first line
    '{64'h0000_0000_0002_0140, 1'b0, 1'b0, 1'b1, 1'b0},  // Refetch evicts way 1
    '{64'h0000_0000_0002_2144, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0000_0000_0002_3148, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0000_0000_0002_414c, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0000_0000_0000_1040, 1'b0, 1'b0, 1'b1, 1'b0},
    '{64'h0000_0000_0000_1040, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0000_0000_0000_1044, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0080_0000_0000_1040, 1'b0, 1'b1, 1'b0, 1'b0},  // Non-canonical
    '{64'h8000_0000_0000_0000, 1'b0, 1'b1, 1'b0, 1'b0},
    '{64'h0000_0100_0000_2000, 1'b0, 1'b1, 1'b1, 1'b0},  // Denied line
    '{64'h0000_0000_0000_3080, 1'b0, 1'b0, 1'b1, 1'b0},
    '{64'h0000_0100_0000_2004, 1'b0, 1'b1, 1'b1, 1'b1},  // Younger hit behind a denial
    '{64'h0000_0000_0000_3084, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0000_0000_0000_2000, 1'b0, 1'b0, 1'b1, 1'b1},  // Younger hit behind a refill
    '{64'h0000_0000_0000_1048, 1'b0, 1'b0, 1'b0, 1'b0},
    '{64'h0000_0000_0000_1040, 1'b1, 1'b0, 1'b1, 1'b0},  // Flush fetch
    '{64'h0000_0000_0002_2140, 1'b0, 1'b0, 1'b1, 1'b0},
    '{64'h0000_0000_0000_1040, 1'b0, 1'b0, 1'b0, 1'b1},  // Hit burst
    '{64'h0000_0000_0000_1044, 1'b0, 1'b0, 1'b0, 1'b1},
    '{64'h0000_0000_0000_104c, 1'b0, 1'b0, 1'b0, 1'b1},
    '{64'h0000_0000_0002_2148, 1'b0, 1'b0, 1'b0, 1'b1},
    '{64'h0000_0000_0002_214c, 1'b0, 1'b0, 1'b0, 1'b0}
  };

  logic                          clk;
  logic                          rst_n;
  logic                          fetch_valid;
  logic                          fetch_ready;
  fetch_req_t                    fetch_req;
  logic                          resp_valid;
  fetch_resp_t                   resp;
  logic                          mem_req_valid;
  logic                          mem_req_ready;
  logic [PhysAddrW-LineOffW-1:0] mem_req_addr;
  logic                          mem_beat_valid;
  logic                          mem_beat_ready;
  mem_beat_t                     mem_beat;

  int unsigned cycle       = 0;
  int unsigned errors      = 0;
  int unsigned rows_done   = 0;
  int unsigned rows_passed = 0;
  int unsigned rows_failed = 0;
  int unsigned cur_row     = 0;
  int unsigned acc_q [$];
  int unsigned accept_edge [NumRows];
  int unsigned miss_cnt [NumRows];
  logic [PhysAddrW-LineOffW-1:0] req_line [NumRows];

  tb_clock_gen u_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  icache_top DUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .fetch_valid_i    (fetch_valid),
    .fetch_ready_o    (fetch_ready),
    .fetch_req_i      (fetch_req),
    .resp_valid_o     (resp_valid),
    .resp_o           (resp),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_req_addr_o   (mem_req_addr),
    .mem_beat_valid_i (mem_beat_valid),
    .mem_beat_ready_o (mem_beat_ready),
    .mem_beat_i       (mem_beat)
  );

  tb_icache_mem u_mem (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (mem_req_valid),
    .req_ready_o  (mem_req_ready),
    .req_addr_i   (mem_req_addr),
    .beat_valid_o (mem_beat_valid),
    .beat_ready_i (mem_beat_ready),
    .beat_o       (mem_beat)
  );

  function automatic logic [31:0] expected_instr(input logic [63:0] addr);
    return addr[31:0] ^ InstrKey;
  endfunction

  // Hits and early faults answer two edges after acceptance unless queued behind a miss
  function automatic logic is_timed(input int unsigned idx);
    return !Rows[idx].miss && !(idx > 0 && Rows[idx-1].chain && Rows[idx-1].miss);
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_row(input int unsigned idx);
    int unsigned errs_before;
    errs_before = errors;
    check_value($sformatf("row %0d fault", idx), 64'(resp.fault), 64'(Rows[idx].fault));
    if (!Rows[idx].fault) begin
      check_value($sformatf("row %0d instruction", idx), 64'(resp.instr),
                  64'(expected_instr(Rows[idx].addr)));
    end
    check_value($sformatf("row %0d memory requests", idx), 64'(miss_cnt[idx]),
                64'(Rows[idx].miss));
    if (miss_cnt[idx] != 0) begin
      check_value($sformatf("row %0d refill line", idx), 64'(req_line[idx]),
                  64'(Rows[idx].addr[PhysAddrW-1:LineOffW]));
    end
    if (is_timed(idx)) begin
      check_value($sformatf("row %0d latency", idx), 64'(cycle - accept_edge[idx]), 64'd2);
    end
    if (idx > 0 && Rows[idx-1].chain) begin
      check_value($sformatf("row %0d accept edge", idx), 64'(accept_edge[idx]),
                  64'(accept_edge[idx-1] + 1));
    end
    rows_done++;
    if (errors == errs_before) begin
      rows_passed++;
      $display("Row %0d addr %h: ok", idx, Rows[idx].addr);
    end else begin
      rows_failed++;
      $display("Row %0d addr %h: failed", idx, Rows[idx].addr);
    end
  endtask

  //////////////////////////////
  // Cycle count and timeout
  //////////////////////////////

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, %0d of %0d rows answered", cycle, rows_done, NumRows);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // A miss seen mid-cycle always belongs to the oldest outstanding row
  always @(negedge clk) begin
    if (rst_n) begin
      if (mem_req_valid && mem_req_ready) begin
        if (acc_q.size() == 0) begin
          $display("Error at %0t: memory request with no fetch outstanding", $time);
          errors++;
        end else begin
          miss_cnt[acc_q[0]]++;
          req_line[acc_q[0]] = mem_req_addr;
        end
      end
      if (resp_valid) begin
        if (acc_q.size() == 0) begin
          $display("Error at %0t: response with no fetch outstanding", $time);
          errors++;
        end else begin
          finish_row(acc_q.pop_front());
        end
      end
      if (fetch_valid && fetch_ready) begin
        acc_q.push_back(cur_row);
        accept_edge[cur_row] = cycle + 1;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    fetch_valid = 1'b0;
    fetch_req   = '0;
    for (int unsigned i = 0; i < NumRows; i++) begin
      miss_cnt[i]    = 0;
      accept_edge[i] = 0;
      req_line[i]    = '0;
    end
    wait (rst_n);
    @(posedge clk);
    for (int unsigned i = 0; i < NumRows; i++) begin
      cur_row = i;
      fetch_valid <= 1'b1;
      fetch_req   <= '{addr: Rows[i].addr, flush: Rows[i].flush};
      @(negedge clk);
      while (!fetch_ready) @(negedge clk);
      @(posedge clk);
      // Chained rows go out on the very next edge
      if (!Rows[i].chain) begin
        fetch_valid <= 1'b0;
        while (acc_q.size() != 0) @(posedge clk);
      end
    end
    repeat (4) @(posedge clk);
    $display("Summary: %0d rows, %0d passed, %0d failed, %0d errors",
             NumRows, rows_passed, rows_failed, errors);
    if (errors == 0 && rows_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_icache_mem.sv
// Behavioral line memory that answers refill requests with rule data or a denial
`timescale 1ns/1ns
`default_nettype none

module tb_icache_mem import icache_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  logic [PhysAddrW-LineOffW-1:0] req_addr_i,

  output logic                          beat_valid_o,
  input  logic                          beat_ready_i,
  output mem_beat_t                     beat_o
);

  localparam logic [31:0] InstrKey = 32'h5a5a0000;
  // Byte address bit 40 seen from the line address
  localparam int unsigned DenyBit  = 40 - LineOffW;

  integer                        seed    = 32'h3c9d6452;
  logic                          ready_q = 1'b0;
  logic                          valid_q = 1'b0;
  mem_beat_t                     beat_q  = '0;
  logic                          busy_q  = 1'b0;
  logic [PhysAddrW-LineOffW-1:0] line_q  = '0;
  logic [BeatsW-1:0]             idx_q   = '0;
  logic [1:0]                    delay_q = '0;

  assign req_ready_o  = ready_q;
  assign beat_valid_o = valid_q;
  assign beat_o       = beat_q;

  // Low half holds the instruction at the word address, high half the next one
  function automatic line_word_t beat_data(input logic [PhysAddrW-LineOffW-1:0] line,
                                           input logic [BeatsW-1:0]             idx);
    logic [63:0] addr;
    addr = {8'h00, line, idx, 3'b000};
    return {(addr[31:0] + 32'd4) ^ InstrKey, addr[31:0] ^ InstrKey};
  endfunction

  function automatic logic [1:0] next_delay();
    return 2'($unsigned($random(seed)) % 3);
  endfunction

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      ready_q <= 1'b0;
      valid_q <= 1'b0;
      busy_q  <= 1'b0;
    end else if (!busy_q) begin
      ready_q <= 1'b1;
      if (req_valid_i && ready_q) begin
        ready_q <= 1'b0;
        busy_q  <= 1'b1;
        line_q  <= req_addr_i;
        idx_q   <= '0;
        delay_q <= next_delay();
      end
    end else if (valid_q) begin
      if (beat_ready_i) begin
        valid_q <= 1'b0;
        if (beat_q.denied || idx_q == BeatsW'(NumBeats - 1)) begin
          busy_q <= 1'b0;
        end else begin
          idx_q   <= idx_q + 1'b1;
          delay_q <= next_delay();
        end
      end
    end else if (delay_q != 2'd0) begin
      delay_q <= delay_q - 1'b1;
    end else begin
      valid_q       <= 1'b1;
      beat_q.denied <= line_q[DenyBit];
      beat_q.data   <= line_q[DenyBit] ? '0 : beat_data(line_q, idx_q);
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge after the given cycle count
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
// Instruction cache top with the pipeline stages, refill, flush and way arrays
`timescale 1ns/1ns
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          fetch_valid_i,
  output logic                          fetch_ready_o,
  input  fetch_req_t                    fetch_req_i,

  output logic                          resp_valid_o,
  output fetch_resp_t                   resp_o,

  output logic                          mem_req_valid_o,
  input  logic                          mem_req_ready_i,
  output logic [PhysAddrW-LineOffW-1:0] mem_req_addr_o,

  input  logic                          mem_beat_valid_i,
  output logic                          mem_beat_ready_o,
  input  mem_beat_t                     mem_beat_i
);

  stage_t                   stage;
  logic                     stall;
  logic                     refill_start;
  logic                     refill_done;
  logic                     refill_denied;
  refill_req_t              refill_req;
  logic                     rd_en;
  logic [SetsW-1:0]         rd_set;
  logic [BeatsW-1:0]        rd_word;
  tag_entry_t [NumWays-1:0] tags;
  line_word_t [NumWays-1:0] words;
  logic                     flush_start;
  logic                     flush_busy;
  logic                     inv_en;
  logic [SetsW-1:0]         inv_set;
  logic                     data_wr_en;
  logic                     tag_wr_en;
  logic [WaysW-1:0]         wr_way;
  logic [SetsW-1:0]         wr_set;
  logic [BeatsW-1:0]        wr_word;
  line_word_t               wr_data;
  tag_entry_t               wr_tag;

  //////////////////////////////
  // Pipeline and control
  //////////////////////////////

  icache_lookup u_lookup (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_req_i   (fetch_req_i),
    .stall_i       (stall),
    .refill_done_i (refill_done),
    .flush_busy_i  (flush_busy),
    .flush_start_o (flush_start),
    .rd_en_o       (rd_en),
    .rd_set_o      (rd_set),
    .rd_word_o     (rd_word),
    .stage_o       (stage)
  );

  icache_hit_select u_hit_select (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stage_i         (stage),
    .tags_i          (tags),
    .words_i         (words),
    .stall_o         (stall),
    .refill_start_o  (refill_start),
    .refill_req_o    (refill_req),
    .refill_done_i   (refill_done),
    .refill_denied_i (refill_denied),
    .resp_valid_o    (resp_valid_o),
    .resp_o          (resp_o)
  );

  icache_refill u_refill (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .refill_start_i   (refill_start),
    .refill_req_i     (refill_req),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_beat_valid_i (mem_beat_valid_i),
    .mem_beat_ready_o (mem_beat_ready_o),
    .mem_beat_i       (mem_beat_i),
    .data_wr_en_o     (data_wr_en),
    .tag_wr_en_o      (tag_wr_en),
    .wr_way_o         (wr_way),
    .wr_set_o         (wr_set),
    .wr_word_o        (wr_word),
    .wr_data_o        (wr_data),
    .wr_tag_o         (wr_tag),
    .refill_done_o    (refill_done),
    .refill_denied_o  (refill_denied)
  );

  icache_flush u_flush (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_start_i (flush_start),
    .flush_busy_o  (flush_busy),
    .inv_en_o      (inv_en),
    .inv_set_o     (inv_set)
  );

  //////////////////////////////
  // Way arrays
  //////////////////////////////

  for (genvar i = 0; i < NumWays; i++) begin : g_way
    logic             way_sel;
    logic             tag_we;
    logic [SetsW-1:0] tag_waddr;
    tag_entry_t       tag_wdata;

    assign way_sel   = wr_way == WaysW'(i);
    // Flush and refill never write in the same cycle
    assign tag_we    = inv_en || (tag_wr_en && way_sel);
    assign tag_waddr = inv_en ? inv_set : wr_set;
    assign tag_wdata = inv_en ? tag_entry_t'('0) : wr_tag;

    icache_way_ram #(
      .entry_t (tag_entry_t),
      .Depth   (2 ** SetsW)
    ) u_tag_ram (
      .clk_i     (clk_i),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_set),
      .rd_data_o (tags[i]),
      .wr_en_i   (tag_we),
      .wr_addr_i (tag_waddr),
      .wr_data_i (tag_wdata)
    );

    icache_way_ram #(
      .entry_t (line_word_t),
      .Depth   (2 ** (SetsW + BeatsW))
    ) u_data_ram (
      .clk_i     (clk_i),
      .rd_en_i   (rd_en),
      .rd_addr_i ({rd_set, rd_word}),
      .rd_data_o (words[i]),
      .wr_en_i   (data_wr_en && way_sel),
      .wr_addr_i ({wr_set, wr_word}),
      .wr_data_i (wr_data)
    );
  end

endmodule

`default_nettype wire

//--- rtl/icache_flush.sv
// Invalidation sequencer that clears every set after reset and on request
`timescale 1ns/1ns
`default_nettype none

module icache_flush import icache_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             flush_start_i,
  output logic             flush_busy_o,

  output logic             inv_en_o,
  output logic [SetsW-1:0] inv_set_o
);

  logic             busy_q;
  logic [SetsW-1:0] set_q;

  assign flush_busy_o = busy_q;
  // Every way of the current set is cleared at once
  assign inv_en_o     = busy_q;
  assign inv_set_o    = set_q;

  // Sweep starts straight out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b1;
      set_q  <= '0;
    end else if (busy_q) begin
      set_q <= set_q + 1'b1;
      if (&set_q) begin
        busy_q <= 1'b0;
      end
    end else if (flush_start_i) begin
      busy_q <= 1'b1;
      set_q  <= '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/icache_refill.sv
// Miss handler FSM that fetches a line and writes its beats and tag
`timescale 1ns/1ns
`default_nettype none

module icache_refill import icache_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          refill_start_i,
  input  refill_req_t                   refill_req_i,

  output logic                          mem_req_valid_o,
  input  logic                          mem_req_ready_i,
  output logic [PhysAddrW-LineOffW-1:0] mem_req_addr_o,

  input  logic                          mem_beat_valid_i,
  output logic                          mem_beat_ready_o,
  input  mem_beat_t                     mem_beat_i,

  output logic                          data_wr_en_o,
  output logic                          tag_wr_en_o,
  output logic [WaysW-1:0]              wr_way_o,
  output logic [SetsW-1:0]              wr_set_o,
  output logic [BeatsW-1:0]             wr_word_o,
  output line_word_t                    wr_data_o,
  output tag_entry_t                    wr_tag_o,

  output logic                          refill_done_o,
  output logic                          refill_denied_o
);

  typedef enum logic [1:0] {
    StIdle,
    StRequest,
    StBeats,
    StDone
  } state_e;

  state_e            state_q;
  state_e            state_d;
  refill_req_t       req_q;
  logic [BeatsW-1:0] beat_q;
  logic [BeatsW:0]   taken_q;
  logic              denied_q;
  logic              beat_fire;
  logic              final_beat;
  logic              last_beat;

  assign mem_req_valid_o  = state_q == StRequest;
  assign mem_req_addr_o   = req_q.line;
  assign mem_beat_ready_o = state_q == StBeats;

  assign beat_fire  = mem_beat_valid_i && mem_beat_ready_o;
  assign final_beat = beat_q == BeatsW'(NumBeats - 1);
  // A denied beat ends the transfer on its own
  assign last_beat  = beat_fire && (mem_beat_i.denied || final_beat);

  assign data_wr_en_o = beat_fire && !mem_beat_i.denied;
  assign tag_wr_en_o  = data_wr_en_o && final_beat;
  assign wr_way_o     = req_q.way;
  assign wr_set_o     = req_q.line[SetsW-1:0];
  assign wr_word_o    = beat_q;
  assign wr_data_o    = mem_beat_i.data;
  assign wr_tag_o     = '{tag: req_q.line[PhysAddrW-LineOffW-1:SetsW], valid: 1'b1};

  assign refill_done_o   = state_q == StDone;
  assign refill_denied_o = refill_done_o && denied_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (refill_start_i) begin
          state_d = StRequest;
        end
      end
      StRequest: begin
        if (mem_req_ready_i) begin
          state_d = StBeats;
        end
      end
      StBeats: begin
        if (last_beat) begin
          state_d = StDone;
        end
      end
      StDone: begin
        state_d = StIdle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= StIdle;
      beat_q   <= '0;
      taken_q  <= '0;
      denied_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == StIdle && refill_start_i) begin
        beat_q   <= '0;
        taken_q  <= '0;
        denied_q <= 1'b0;
      end else if (beat_fire) begin
        beat_q   <= beat_q + 1'b1;
        taken_q  <= taken_q + 1'b1;
        denied_q <= mem_beat_i.denied;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && refill_start_i) begin
      req_q <= refill_req_i;
    end
  end

  // A refill never takes more beats than one line holds
  beat_limit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) beat_fire |-> taken_q < NumBeats
  );

endmodule

`default_nettype wire

//--- rtl/icache_hit_select.sv
// Tag compare, victim choice, eviction pointer and response generation
`timescale 1ns/1ns
`default_nettype none

module icache_hit_select import icache_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  stage_t                   stage_i,
  input  tag_entry_t [NumWays-1:0] tags_i,
  input  line_word_t [NumWays-1:0] words_i,

  output logic                     stall_o,
  output logic                     refill_start_o,
  output refill_req_t              refill_req_o,
  input  logic                     refill_done_i,
  input  logic                     refill_denied_i,

  output logic                     resp_valid_o,
  output fetch_resp_t              resp_o
);

  logic [NumWays-1:0] hit;
  logic [WaysW-1:0]   hit_way;
  logic [WaysW-1:0]   victim_way;
  logic [WaysW-1:0]   evict_q;
  logic               busy_q;
  logic               active;
  logic               miss;
  logic               deny_done;
  logic               resp_fault;
  line_word_t         hit_word;

  //////////////////////////////
  // Tag compare
  //////////////////////////////

  always_comb begin
    hit        = '0;
    hit_way    = '0;
    victim_way = evict_q;
    // Walk downwards so the lowest numbered way wins
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (tags_i[i].valid &&
          tags_i[i].tag == stage_i.addr[PhysAddrW-1:LineOffW+SetsW]) begin
        hit[i]  = 1'b1;
        hit_way = WaysW'(i);
      end
      if (!tags_i[i].valid) begin
        victim_way = WaysW'(i);
      end
    end
  end

  // Stage item is ignored while a refill is outstanding
  assign active     = stage_i.valid && !busy_q;
  assign miss       = active && !stage_i.fault && !(|hit);
  assign deny_done  = busy_q && refill_done_i && refill_denied_i;
  assign stall_o    = miss || (busy_q && !deny_done);
  assign hit_word   = words_i[hit_way];
  assign resp_fault = stage_i.fault || deny_done;

  //////////////////////////////
  // State and responses
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q         <= 1'b0;
      evict_q        <= '0;
      refill_start_o <= 1'b0;
      resp_valid_o   <= 1'b0;
    end else begin
      refill_start_o <= miss;
      resp_valid_o   <= (active && (stage_i.fault || |hit)) || deny_done;
      if (miss) begin
        busy_q  <= 1'b1;
        evict_q <= evict_q + 1'b1;
      end else if (refill_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss) begin
      refill_req_o.line <= stage_i.addr[PhysAddrW-1:LineOffW];
      refill_req_o.way  <= victim_way;
    end
    resp_o.fault <= resp_fault;
    if (resp_fault) begin
      resp_o.instr <= '0;
    end else begin
      resp_o.instr <= stage_i.addr[2] ? hit_word[63:32] : hit_word[31:0];
    end
  end

  // Refill and flush keep each line in at most one way
  one_hot_hit: assert property (
    @(posedge clk_i) disable iff (!rst_ni) active |-> $onehot0(hit)
  );

endmodule

`default_nettype wire

//--- rtl/icache_lookup.sv
// Fetch acceptance stage with canonical address check, array reads and replay
`timescale 1ns/1ns
`default_nettype none

module icache_lookup import icache_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              fetch_valid_i,
  output logic              fetch_ready_o,
  input  fetch_req_t        fetch_req_i,

  input  logic              stall_i,
  input  logic              refill_done_i,
  input  logic              flush_busy_i,
  output logic              flush_start_o,

  output logic              rd_en_o,
  output logic [SetsW-1:0]  rd_set_o,
  output logic [BeatsW-1:0] rd_word_o,
  output stage_t            stage_o
);

  stage_t cur_q;
  stage_t new_item;
  stage_t rd_item;
  logic   flushed_q;
  logic   pipe_empty;
  logic   fetch_fire;
  logic   replay;

  assign pipe_empty = !cur_q.valid && !stage_o.valid;

  // A flush fetch is held back until its sweep has run
  assign fetch_ready_o = !stall_i && !flush_busy_i && (!fetch_req_i.flush || flushed_q);
  assign fetch_fire    = fetch_valid_i && fetch_ready_o;
  assign flush_start_o = fetch_valid_i && fetch_req_i.flush && !flushed_q && pipe_empty &&
                         !flush_busy_i;

  always_comb begin
    new_item       = '0;
    new_item.valid = fetch_fire;
    new_item.addr  = fetch_req_i.addr[PhysAddrW-1:2];
    // Physical addresses beyond the implemented width fault without touching the arrays
    new_item.fault = |fetch_req_i.addr[63:PhysAddrW-1];
  end

  // Refill done under stall re-reads the missed item, younger one waits in cur_q
  assign replay    = stall_i && refill_done_i;
  assign rd_item   = replay ? stage_o : cur_q;
  assign rd_en_o   = rd_item.valid && !rd_item.fault && (!stall_i || refill_done_i);
  assign rd_set_o  = rd_item.addr[LineOffW+SetsW-1:LineOffW];
  assign rd_word_o = rd_item.addr[LineOffW-1:3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_q     <= '0;
      stage_o   <= '0;
      flushed_q <= 1'b0;
    end else begin
      if (!stall_i) begin
        cur_q   <= new_item;
        stage_o <= cur_q;
      end
      if (flush_start_o) begin
        flushed_q <= 1'b1;
      end else if (fetch_fire) begin
        flushed_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/icache_way_ram.sv
// Storage array of one cache way with a registered read port and a write port
`timescale 1ns/1ns
`default_nettype none

module icache_way_ram #(
  parameter type         entry_t = logic [63:0],
  parameter int unsigned Depth   = 64
) (
  input  logic                     clk_i,

  input  logic                     rd_en_i,
  input  logic [$clog2(Depth)-1:0] rd_addr_i,
  output entry_t                   rd_data_o,

  input  logic                     wr_en_i,
  input  logic [$clog2(Depth)-1:0] wr_addr_i,
  input  entry_t                   wr_data_i
);

  entry_t mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Output holds its value while no read is issued
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

  // Refill and flush writes must never meet a lookup read of the same entry
  rd_wr_no_collision: assert property (
    @(posedge clk_i) !(rd_en_i && wr_en_i && rd_addr_i == wr_addr_i)
  );

endmodule

`default_nettype wire

//--- rtl/icache_pkg.sv
// Cache geometry constants and the structs shared between the cache blocks
`default_nettype none

package icache_pkg;

  // Geometry
  localparam int unsigned PhysAddrW = 56;
  localparam int unsigned WaysW     = 2;
  localparam int unsigned NumWays   = 4;
  localparam int unsigned SetsW     = 6;
  localparam int unsigned BeatsW    = 3;
  localparam int unsigned NumBeats  = 8;
  localparam int unsigned LineOffW  = 6;
  localparam int unsigned TagW      = PhysAddrW - SetsW - LineOffW;

  typedef struct packed {
    logic [63:0] addr;
    logic        flush;
  } fetch_req_t;

  typedef struct packed {
    logic [31:0] instr;
    logic        fault;
  } fetch_resp_t;

  typedef struct packed {
    logic [TagW-1:0] tag;
    logic            valid;
  } tag_entry_t;

  typedef logic [63:0] line_word_t;

  // Item handed from lookup to hit select, address kept down to the word half
  typedef struct packed {
    logic                 valid;
    logic [PhysAddrW-1:2] addr;
    logic                 fault;
  } stage_t;

  typedef struct packed {
    logic [PhysAddrW-LineOffW-1:0] line;
    logic [WaysW-1:0]              way;
  } refill_req_t;

  typedef struct packed {
    line_word_t data;
    logic       denied;
  } mem_beat_t;

endpackage

`default_nettype wire
